//--- build.f
stream_pkg.sv
stream_if.sv
stream_fifo.sv
ndata_skid_buffer.sv
stream_decoupler.sv
stream_coupler.sv
stream_top.sv
tb_stream_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_stream_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)
PASS_TEXT ?= All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_stream_top.sv
module tb_stream_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N       = 4;
    localparam int WW      = stream_pkg::WORD_WIDTH;
    localparam int TIMEOUT = 200; // Cycles allowed for any single wait.

    typedef logic [N*WW-1:0] beat_data_t;

    logic         clk;
    logic         i_arst_n;
    logic         i_valid;
    logic         o_ready;
    beat_data_t   i_data;
    logic [N-1:0] i_keep;
    logic         i_last;
    logic         o_valid;
    logic         i_ready;
    beat_data_t   o_data;
    logic [N-1:0] o_keep;
    logic         o_last;

    integer       seed           = 32'hd87c527f;
    int           cycle          = 0;
    logic         ready_random   = 1'b0; // Output ready is randomized while set.
    int           value_errors   = 0;
    int           other_errors   = 0;
    int           timeout_errors = 0;

    // Reference model of the beats still in flight.
    beat_data_t   exp_data_q [$];
    logic [N-1:0] exp_keep_q [$];
    logic         exp_last_q [$];
    beat_data_t   exp_data;
    logic [N-1:0] exp_keep;
    logic         exp_last;

    logic         stalled = 1'b0;
    beat_data_t   held_data;
    logic [N-1:0] held_keep;
    logic         held_last;

    stream_top stream_top_inst (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_valid  (i_valid),
        .o_ready  (o_ready),
        .i_data   (i_data),
        .i_keep   (i_keep),
        .i_last   (i_last),
        .o_valid  (o_valid),
        .i_ready  (i_ready),
        .o_data   (o_data),
        .o_keep   (o_keep),
        .o_last   (o_last)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic check_word(input string name, input stream_pkg::word_t got,
                              input stream_pkg::word_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_keep(input string name, input stream_pkg::keep_t got,
                              input stream_pkg::keep_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_last(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            value_errors++;
        end
    endtask

    // Sampled mid-cycle, so every value seen here is the one the next rising edge uses.
    always @(negedge clk) begin
        if (!i_arst_n) begin
            stalled = 1'b0;
        end else begin
            if (i_valid && o_ready) begin
                exp_data_q.push_back(i_data);
                exp_keep_q.push_back(i_keep);
                exp_last_q.push_back(i_last);
            end
            if (stalled) begin // A stalled beat must hold every bit.
                check_last("o_valid", o_valid, 1'b1);
                check_keep("o_keep", stream_pkg::keep_t'(o_keep), stream_pkg::keep_t'(held_keep));
                check_last("o_last", o_last, held_last);
                for (int i = 0; i < N; i++)
                    check_word($sformatf("o_data[%0d]", i), o_data[i*WW +: WW],
                               held_data[i*WW +: WW]);
            end
            if (o_valid && i_ready) begin
                if (exp_data_q.size() == 0) begin
                    $display("An output beat appeared while no beat was expected.");
                    other_errors++;
                end else begin
                    exp_data = exp_data_q.pop_front();
                    exp_keep = exp_keep_q.pop_front();
                    exp_last = exp_last_q.pop_front();
                    check_keep("o_keep", stream_pkg::keep_t'(o_keep), stream_pkg::keep_t'(exp_keep));
                    check_last("o_last", o_last, exp_last);
                    for (int i = 0; i < N; i++)
                        if (exp_keep[i])
                            check_word($sformatf("o_data[%0d]", i), o_data[i*WW +: WW],
                                       exp_data[i*WW +: WW]);
                end
            end
            stalled   = o_valid && !i_ready;
            held_data = o_data;
            held_keep = o_keep;
            held_last = o_last;
        end
    end

    // Advances to just after the next rising edge, where inputs change.
    task automatic step_cycle();
        logic [31:0] rnd;
        @(posedge clk);
        #2;
        if (ready_random) begin
            rnd     = $random(seed);
            i_ready = rnd[0];
        end
    endtask

    task automatic idle_input();
        i_valid = 1'b0;
        i_data  = '0;
        i_keep  = '0;
        i_last  = 1'b0;
    endtask

    task automatic random_beat(output beat_data_t data, output logic [N-1:0] keep,
                               output logic last);
        logic [31:0] rnd;
        for (int i = 0; i < N; i++) begin
            rnd              = $random(seed);
            data[i*WW +: WW] = rnd[WW-1:0];
        end
        rnd  = $random(seed);
        keep = rnd[N-1:0];
        last = rnd[N];
    endtask

    // Offers one beat and returns the edge at which it was taken, or -1.
    task automatic send_beat(input beat_data_t data, input logic [N-1:0] keep, input logic last,
                             output int accept_edge);
        int   waited;
        logic accepted;
        waited      = 0;
        accepted    = 1'b0;
        accept_edge = -1;
        i_valid     = 1'b1;
        i_data      = data;
        i_keep      = keep;
        i_last      = last;
        while (!accepted && waited < TIMEOUT) begin
            @(negedge clk);
            accepted = o_ready;
            step_cycle();
            waited++;
        end
        if (accepted) begin
            accept_edge = cycle;
        end else begin
            $display("Timeout: an input beat was not accepted within %0d cycles.", TIMEOUT);
            timeout_errors++;
            i_valid = 1'b0;
        end
    endtask

    task automatic send_random(input int count, input logic full_keep);
        beat_data_t   data;
        logic [N-1:0] keep;
        logic         last;
        int           edge_no;
        for (int i = 0; i < count; i++) begin
            random_beat(data, keep, last);
            if (full_keep) keep = '1;
            send_beat(data, keep, last, edge_no);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_data_q.size() != 0 || o_valid) && waited < TIMEOUT) begin
            step_cycle();
            waited++;
        end
        if (exp_data_q.size() != 0 || o_valid) begin
            $display("Timeout: %0d beats still pending after %0d cycles.",
                     exp_data_q.size(), TIMEOUT);
            timeout_errors++;
        end
    endtask

    task automatic reset_release();
        int waited;
        waited = 0;
        check_last("o_valid", o_valid, 1'b0);
        check_last("o_ready", o_ready, 1'b0);
        i_arst_n = 1'b1;
        while (!o_ready && waited < TIMEOUT) begin
            step_cycle();
            waited++;
        end
        if (!o_ready) begin
            $display("Timeout: o_ready never rose after reset release.");
            timeout_errors++;
        end
        check_last("o_valid", o_valid, 1'b0);
    endtask

    task automatic single_full_beat();
        beat_data_t   data;
        logic [N-1:0] keep;
        logic         last;
        int           accept_edge;
        int           waited;
        waited = 0;
        random_beat(data, keep, last);
        send_beat(data, '1, 1'b1, accept_edge);
        idle_input();
        while (!o_valid && waited < TIMEOUT) begin
            step_cycle();
            waited++;
        end
        if (!o_valid) begin
            $display("Timeout: the single beat never reached the output.");
            timeout_errors++;
        end else if (accept_edge >= 0 && cycle - accept_edge < 2) begin
            $display("Beat came out %0d edges after acceptance, sooner than two.",
                     cycle - accept_edge);
            other_errors++;
        end
        wait_drain();
    endtask

    task automatic partial_keep_patterns();
        logic [N:0]   patterns [8]; // Last on top, keep below.
        beat_data_t   data;
        logic [N-1:0] keep;
        logic         last;
        int           edge_no;
        patterns = '{5'b0_0001, 5'b1_1010, 5'b0_0110, 5'b0_1000,
                     5'b1_0000, 5'b1_0111, 5'b0_1101, 5'b1_0000};
        foreach (patterns[i]) begin
            random_beat(data, keep, last);
            send_beat(data, patterns[i][N-1:0], patterns[i][N], edge_no);
        end
        idle_input();
        wait_drain();
    endtask

    task automatic random_stream();
        i_ready = 1'b1;
        send_random(40, 1'b0);
        idle_input();
        wait_drain();
    endtask

    task automatic backpressure_drain();
        beat_data_t   data;
        logic [N-1:0] keep;
        logic         last;
        logic         dropped;
        int           waited;
        int           edge_no;
        dropped = 1'b0;
        waited  = 0;
        i_ready = 1'b0;
        random_beat(data, keep, last);
        i_valid = 1'b1;
        i_data  = data;
        i_keep  = '1;
        i_last  = last;
        while (!dropped && waited < TIMEOUT) begin
            @(negedge clk);
            dropped = !o_ready;
            step_cycle();
            if (!dropped) begin // That beat was taken, so offer a fresh one.
                random_beat(data, keep, last);
                i_data = data;
                i_last = last;
            end
            waited++;
        end
        if (!dropped) begin
            $display("Timeout: o_ready stayed high with the output stalled.");
            timeout_errors++;
        end
        repeat (5) begin
            @(negedge clk);
            check_last("o_ready", o_ready, 1'b0);
            step_cycle();
        end
        ready_random = 1'b1;
        send_beat(data, '1, last, edge_no);
        send_random(10, 1'b0);
        idle_input();
        wait_drain();
        ready_random = 1'b0;
        i_ready      = 1'b1;
    endtask

    task automatic uneven_lanes();
        beat_data_t   data;
        logic [N-1:0] keep;
        logic         last;
        int           edge_no;
        for (int burst = 0; burst < 4; burst++) begin
            if (burst == 2) ready_random = 1'b1;
            for (int i = 0; i < 10; i++) begin
                random_beat(data, keep, last);
                keep = '1;
                if (burst % 2 == 0) begin
                    keep        = '0;
                    keep[burst] = 1'b1; // Only one lane busy while the others sit idle.
                end
                send_beat(data, keep, last, edge_no);
            end
        end
        idle_input();
        wait_drain();
        ready_random = 1'b0;
        i_ready      = 1'b1;
    endtask

    initial begin
        i_arst_n = 1'b0;
        i_ready  = 1'b1;
        idle_input();
        repeat (10) @(posedge clk);
        #2;
        reset_release();
        single_full_beat();
        partial_keep_patterns();
        random_stream();
        backpressure_drain();
        uneven_lanes();
        if (exp_data_q.size() != 0) begin
            $display("%0d accepted beats never came out.", exp_data_q.size());
            other_errors++;
        end
        $display("Errors: %0d value, %0d other, %0d timeout",
                 value_errors, other_errors, timeout_errors);
        if (value_errors + other_errors + timeout_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- stream_top.sv
module stream_top #(
    parameter int NUM_ELEMENTS       = 4,
    parameter int LANE_DEPTH         = 4,
    parameter int MAX_IN_TRANSIT     = 8,
    parameter int ENABLE_SKID_BUFFER = 1
) (
    input  logic                                       clk,
    input  logic                                       i_arst_n,

    input  logic                                       i_valid,
    output logic                                       o_ready,
    input  logic [NUM_ELEMENTS*stream_pkg::WORD_WIDTH-1:0] i_data,
    input  logic [NUM_ELEMENTS-1:0]                    i_keep,
    input  logic                                       i_last,

    output logic                                       o_valid,
    input  logic                                       i_ready,
    output logic [NUM_ELEMENTS*stream_pkg::WORD_WIDTH-1:0] o_data,
    output logic [NUM_ELEMENTS-1:0]                    o_keep,
    output logic                                       o_last
);

    stream_pkg::beat_mask_t mask;
    logic                   mask_valid;
    logic                   mask_ready;

    beat_stream_if #(.NUM_ELEMENTS(NUM_ELEMENTS)) beat_in  ();
    beat_stream_if #(.NUM_ELEMENTS(NUM_ELEMENTS)) beat_out ();

    lane_stream_if lane_push [NUM_ELEMENTS] (); // Decoupler to lane FIFOs.
    lane_stream_if lane_pop  [NUM_ELEMENTS] (); // Lane FIFOs to coupler.

    assign beat_in.valid = i_valid;
    assign beat_in.data  = i_data;
    assign beat_in.keep  = stream_pkg::keep_t'(i_keep);
    assign beat_in.last  = i_last;
    assign o_ready       = beat_in.ready;

    assign o_valid        = beat_out.valid;
    assign o_data         = beat_out.data;
    assign o_keep         = beat_out.keep[NUM_ELEMENTS-1:0];
    assign o_last         = beat_out.last;
    assign beat_out.ready = i_ready;

    stream_decoupler #(
        .NUM_ELEMENTS (NUM_ELEMENTS)
    ) decoupler_inst (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .in           (beat_in),
        .lanes        (lane_push),
        .o_mask       (mask),
        .o_mask_valid (mask_valid),
        .i_mask_ready (mask_ready)
    );

    for (genvar g = 0; g < NUM_ELEMENTS; g++) begin : g_lane_fifo
        stream_fifo #(
            .DEPTH (LANE_DEPTH),
            .WIDTH ($bits(stream_pkg::word_t))
        ) lane_fifo_inst (
            .clk      (clk),
            .i_arst_n (i_arst_n),
            .i_data   (lane_push[g].data),
            .i_valid  (lane_push[g].valid),
            .o_ready  (lane_push[g].ready),
            .o_data   (lane_pop[g].data),
            .o_valid  (lane_pop[g].valid),
            .i_ready  (lane_pop[g].ready)
        );
    end

    stream_coupler #(
        .NUM_ELEMENTS       (NUM_ELEMENTS),
        .MAX_IN_TRANSIT     (MAX_IN_TRANSIT),
        .ENABLE_SKID_BUFFER (ENABLE_SKID_BUFFER)
    ) coupler_inst (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_mask       (mask),
        .i_mask_valid (mask_valid),
        .o_mask_ready (mask_ready),
        .lanes        (lane_pop),
        .out          (beat_out)
    );

endmodule

//--- stream_coupler.sv
module stream_coupler #(
    parameter int NUM_ELEMENTS       = 4,
    parameter int MAX_IN_TRANSIT     = 8,
    parameter int ENABLE_SKID_BUFFER = 1
) (
    input  logic                   clk,
    input  logic                   i_arst_n,

    input  stream_pkg::beat_mask_t i_mask,
    input  logic                   i_mask_valid,
    output logic                   o_mask_ready,

    lane_stream_if.snk             lanes [NUM_ELEMENTS],
    beat_stream_if.src             out
);

    stream_pkg::beat_mask_t  cur_mask;
    logic                    cur_mask_valid;
    stream_pkg::keep_t       cur_keep_full;
    logic [NUM_ELEMENTS-1:0] cur_keep;
    logic [NUM_ELEMENTS-1:0] lane_valid;
    logic                    beat_complete;
    logic                    mask_pop;

    beat_stream_if #(.NUM_ELEMENTS(NUM_ELEMENTS)) beat_int ();

    // Masks of beats whose words are still on their way through the lanes.
    stream_fifo #(
        .DEPTH (MAX_IN_TRANSIT),
        .WIDTH ($bits(stream_pkg::beat_mask_t))
    ) mask_fifo_inst (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_data   (i_mask),
        .i_valid  (i_mask_valid),
        .o_ready  (o_mask_ready),
        .o_data   (cur_mask),
        .o_valid  (cur_mask_valid),
        .i_ready  (mask_pop)
    );

    assign cur_keep_full = stream_pkg::mask_keep(cur_mask);
    assign cur_keep      = cur_keep_full[NUM_ELEMENTS-1:0];

    assign beat_complete = cur_mask_valid && ((lane_valid & cur_keep) == cur_keep);
    assign mask_pop      = beat_complete && beat_int.ready;

    for (genvar g = 0; g < NUM_ELEMENTS; g++) begin : g_lane
        assign lane_valid[g]     = lanes[g].valid;
        assign lanes[g].ready    = cur_keep[g] && mask_pop;
        assign beat_int.data[g]  = cur_keep[g] ? lanes[g].data : '0;

        // A word that the current beat leaves out stays at the head of its lane.
        a_unkept_lane_held : assert property (@(posedge clk) disable iff (!i_arst_n)
            lanes[g].valid && !cur_keep[g] |=> lanes[g].valid && $stable(lanes[g].data))
            else $error("Lane popped while its keep bit is clear.");
    end

    assign beat_int.valid = beat_complete;
    assign beat_int.keep  = stream_pkg::keep_t'(cur_keep);
    assign beat_int.last  = stream_pkg::mask_last(cur_mask);

    if (ENABLE_SKID_BUFFER != 0) begin : g_skid
        ndata_skid_buffer #(
            .NUM_ELEMENTS (NUM_ELEMENTS)
        ) skid_inst (
            .clk      (clk),
            .i_arst_n (i_arst_n),
            .in       (beat_int),
            .out      (out)
        );
    end else begin : g_direct
        assign out.valid      = beat_int.valid;
        assign out.data       = beat_int.data;
        assign out.keep       = beat_int.keep;
        assign out.last       = beat_int.last;
        assign beat_int.ready = out.ready;
    end

endmodule

//--- stream_decoupler.sv
module stream_decoupler #(
    parameter int NUM_ELEMENTS = 4
) (
    input  logic                   clk,
    input  logic                   i_arst_n,

    beat_stream_if.snk             in,
    lane_stream_if.src             lanes [NUM_ELEMENTS],

    output stream_pkg::beat_mask_t o_mask,
    output logic                   o_mask_valid,
    input  logic                   i_mask_ready
);

    logic [NUM_ELEMENTS-1:0] kept;
    logic [NUM_ELEMENTS-1:0] lane_ready;
    logic [NUM_ELEMENTS-1:0] lane_push;
    logic                    lanes_ok;  // Every kept lane can take its word.
    logic                    mask_push;

    assign kept = in.keep[NUM_ELEMENTS-1:0];

    // Lanes whose keep bit is clear do not hold the beat back.
    assign lanes_ok = &(lane_ready | ~kept);

    assign in.ready = i_mask_ready && lanes_ok;

    // A beat with no kept element still sends its mask, so last gets through.
    assign o_mask_valid = in.valid && lanes_ok;
    assign o_mask       = stream_pkg::make_mask(stream_pkg::keep_t'(kept), in.last);
    assign mask_push    = o_mask_valid && i_mask_ready;

    for (genvar g = 0; g < NUM_ELEMENTS; g++) begin : g_lane
        assign lane_ready[g] = lanes[g].ready;
        assign lanes[g].data = in.data[g];

        // Only push a word in the same cycle the whole beat is accepted.
        assign lanes[g].valid = in.valid && kept[g] && i_mask_ready && lanes_ok;

        assign lane_push[g] = lanes[g].valid && lanes[g].ready;
    end

    // Lane pushes and the mask push go together, and cover exactly the kept lanes.
    a_lanes_follow_mask : assert property (@(posedge clk) disable iff (!i_arst_n)
        (mask_push || (|lane_push)) |-> (mask_push && (lane_push == kept)))
        else $error("Lane pushes do not match the mask push.");

endmodule

//--- ndata_skid_buffer.sv
module ndata_skid_buffer #(
    parameter int NUM_ELEMENTS = 4
) (
    input logic         clk,
    input logic         i_arst_n,

    beat_stream_if.snk  in,
    beat_stream_if.src  out
);

    typedef enum logic [1:0] {
        SKID_EMPTY,
        SKID_BUSY,  // Main register holds a beat.
        SKID_FULL   // Main and spare both hold a beat.
    } skid_state_e;

    typedef stream_pkg::word_t [NUM_ELEMENTS-1:0] words_t;

    skid_state_e       state;
    skid_state_e       state_next;
    words_t            main_data;
    stream_pkg::keep_t main_keep;
    logic              main_last;
    words_t            spare_data;
    stream_pkg::keep_t spare_keep;
    logic              spare_last;
    logic              in_fire;
    logic              out_fire;
    logic              load_main_in;
    logic              load_main_spare;
    logic              load_spare;

    // Ready comes straight from the state register, which cuts the ready chain.
    assign in.ready  = (state != SKID_FULL);
    assign out.valid = (state != SKID_EMPTY);
    assign out.data  = main_data;
    assign out.keep  = main_keep;
    assign out.last  = main_last;

    assign in_fire  = in.valid && in.ready;
    assign out_fire = out.valid && out.ready;

    always_comb begin
        state_next      = state;
        load_main_in    = 1'b0;
        load_main_spare = 1'b0;
        load_spare      = 1'b0;
        unique case (state)
            SKID_EMPTY: begin
                if (in_fire) begin
                    load_main_in = 1'b1;
                    state_next   = SKID_BUSY;
                end
            end
            SKID_BUSY: begin
                if (in_fire && out_fire) begin
                    load_main_in = 1'b1;
                end else if (in_fire) begin
                    load_spare = 1'b1; // Downstream stalled, park the beat.
                    state_next = SKID_FULL;
                end else if (out_fire) begin
                    state_next = SKID_EMPTY;
                end
            end
            SKID_FULL: begin
                if (out_fire) begin
                    load_main_spare = 1'b1;
                    state_next      = SKID_BUSY;
                end
            end
            default: state_next = SKID_EMPTY;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) state <= SKID_EMPTY;
        else           state <= state_next;
    end

    always_ff @(posedge clk) begin
        if (load_main_in) begin
            main_data <= in.data;
            main_keep <= in.keep;
            main_last <= in.last;
        end else if (load_main_spare) begin
            main_data <= spare_data;
            main_keep <= spare_keep;
            main_last <= spare_last;
        end
        if (load_spare) begin
            spare_data <= in.data;
            spare_keep <= in.keep;
            spare_last <= in.last;
        end
    end

    a_out_stable : assert property (@(posedge clk) disable iff (!i_arst_n)
        out.valid && !out.ready |=> out.valid && $stable(out.data)
                                  && $stable(out.keep) && $stable(out.last))
        else $error("Skid buffer output changed while stalled.");

endmodule

//--- stream_fifo.sv
module stream_fifo #(
    parameter int DEPTH = 4,
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             i_arst_n,

    input  logic [WIDTH-1:0] i_data,
    input  logic             i_valid,
    output logic             o_ready,

    output logic [WIDTH-1:0] o_data,
    output logic             o_valid,
    input  logic             i_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] count_t;

    logic [WIDTH-1:0] mem [DEPTH];
    ptr_t             wr_ptr;
    ptr_t             rd_ptr;
    count_t           count;      // Entries in memory, the output stage not included.
    count_t           count_next;
    logic             push;
    logic             load;       // Moves the oldest entry into the output stage.
    logic             ready_q;
    logic             out_valid_q;
    logic [WIDTH-1:0] out_data_q;

    function automatic ptr_t next_ptr(ptr_t ptr);
        return (ptr == ptr_t'(DEPTH - 1)) ? '0 : ptr + ptr_t'(1);
    endfunction

    assign push       = i_valid && ready_q;
    assign load       = (count != '0) && (!out_valid_q || i_ready);
    assign count_next = count + count_t'(push) - count_t'(load);

    assign o_ready = ready_q; // Registered, so it never sees this cycle's pop.
    assign o_valid = out_valid_q;
    assign o_data  = out_data_q;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            ready_q     <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (load) rd_ptr <= next_ptr(rd_ptr);
            count   <= count_next;
            ready_q <= (count_next != count_t'(DEPTH));
            if (load) begin
                out_valid_q <= 1'b1;
            end else if (i_ready) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= i_data;
        if (load) out_data_q <= mem[rd_ptr];
    end

    // The registered ready must close before the memory overflows.
    a_no_push_full : assert property (@(posedge clk) disable iff (!i_arst_n)
        (count == count_t'(DEPTH)) |-> !push)
        else $error("Push into a full FIFO.");

    // The output stage only turns valid from an entry stored the cycle before.
    a_no_pop_empty : assert property (@(posedge clk) disable iff (!i_arst_n)
        !o_valid ##1 o_valid |-> ($past(count) != '0))
        else $error("Pop from an empty FIFO.");

endmodule

//--- stream_if.sv
// A single lane of data words with a ready/valid handshake.
interface lane_stream_if;

    logic              valid;
    logic              ready;
    stream_pkg::word_t data;

    modport src (
        output valid,
        output data,
        input  ready
    );

    modport snk (
        input  valid,
        input  data,
        output ready
    );

endinterface

// A full beat of NUM_ELEMENTS words with keep and last.
interface beat_stream_if #(
    parameter int NUM_ELEMENTS = 4
);

    logic                                 valid;
    logic                                 ready;
    stream_pkg::word_t [NUM_ELEMENTS-1:0] data;
    stream_pkg::keep_t                    keep; // Only the low NUM_ELEMENTS bits carry meaning.
    logic                                 last;

    modport src (
        output valid,
        output data,
        output keep,
        output last,
        input  ready
    );

    modport snk (
        input  valid,
        input  data,
        input  keep,
        input  last,
        output ready
    );

endinterface

//--- stream_pkg.sv
package stream_pkg;

    // One lane carries a single data word.
    localparam int WORD_WIDTH = 16;
    typedef logic [WORD_WIDTH-1:0] word_t;

    // Upper bound on the lane count. The keep vector is sized for it.
    localparam int MAX_ELEMENTS = 8;
    typedef logic [MAX_ELEMENTS-1:0] keep_t;

    // A beat mask holds the keep bits in the low part and the last bit on top.
    localparam int MASK_LAST_BIT = MAX_ELEMENTS;
    typedef logic [MAX_ELEMENTS:0] beat_mask_t;

    function automatic beat_mask_t make_mask(keep_t keep, logic last);
        return {last, keep};
    endfunction

    function automatic keep_t mask_keep(beat_mask_t mask);
        return mask[MAX_ELEMENTS-1:0];
    endfunction

    function automatic logic mask_last(beat_mask_t mask);
        return mask[MASK_LAST_BIT];
    endfunction

endpackage
